// File: run_sim.sh
#!/usr/bin/env bash
# builds the srcpu testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_srcpu -f srcpu.f \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_srcpu 2>&1 | tee sim.log

# the log decides the verdict
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: run ended early"; exit 1; }

echo "PASS"
exit 0

// File: srcpu.f
+incdir+.
srcpu_isa_pkg.sv
srcpu_dp_pkg.sv
srcpu_booth_mul.sv
srcpu_alu.sv
srcpu_divider.sv
srcpu_regfile.sv
srcpu_control.sv
srcpu_top.sv
tb_srcpu.sv

// File: srcpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "srcpu_defs.svh"

module srcpu_alu (
	input  wire srcpu_dp_pkg::word_t  a,    // from Y
	input  wire srcpu_dp_pkg::word_t  b,    // from the bus
	input  wire srcpu_isa_pkg::op_t   op,
	output srcpu_dp_pkg::dword_t      c
);

	localparam int w    = `SRC_WORD_W;
	localparam int sh_w = $clog2(`SRC_WORD_W);

	srcpu_dp_pkg::word_t and_r;
	srcpu_dp_pkg::word_t or_r;
	srcpu_dp_pkg::word_t add_r;
	srcpu_dp_pkg::word_t sub_r;
	srcpu_dp_pkg::word_t shr_r;
	srcpu_dp_pkg::word_t shra_r;
	srcpu_dp_pkg::word_t shl_r;
	srcpu_dp_pkg::word_t ror_r;
	srcpu_dp_pkg::word_t rol_r;
	srcpu_dp_pkg::word_t neg_r;
	srcpu_dp_pkg::word_t not_r;
	srcpu_dp_pkg::dword_t mul_r;
	logic [sh_w-1:0] sh;
	logic [2*w-1:0]  rot_r;
	logic [2*w-1:0]  rot_l;

	assign sh = b[sh_w-1:0];   // only the low five bits count

	assign and_r = a & b;
	assign or_r  = a | b;
	assign add_r = a + b;
	assign sub_r = a - b;

	// neg and not work on the Y side
	assign neg_r = -a;
	assign not_r = ~a;

	assign shr_r  = a >> sh;
	assign shra_r = $signed(a) >>> sh;
	assign shl_r  = a << sh;

	// doubled word makes the rotates plain shifts
	assign rot_r = {a, a} >> sh;
	assign rot_l = {a, a} << sh;
	assign ror_r = rot_r[w-1:0];
	assign rol_r = rot_l[2*w-1:w];

	srcpu_booth_mul u_mul (
		.m       (a),
		.q       (b),
		.product (mul_r)
	);

	always_comb begin
		c = '0;
		case (op)
			srcpu_isa_pkg::op_ldi:  c.lo = b;
			srcpu_isa_pkg::op_add,
			srcpu_isa_pkg::op_addi: c.lo = add_r;
			srcpu_isa_pkg::op_sub:  c.lo = sub_r;
			srcpu_isa_pkg::op_and,
			srcpu_isa_pkg::op_andi: c.lo = and_r;
			srcpu_isa_pkg::op_or,
			srcpu_isa_pkg::op_ori:  c.lo = or_r;
			srcpu_isa_pkg::op_shr:  c.lo = shr_r;
			srcpu_isa_pkg::op_shra: c.lo = shra_r;
			srcpu_isa_pkg::op_shl:  c.lo = shl_r;
			srcpu_isa_pkg::op_ror:  c.lo = ror_r;
			srcpu_isa_pkg::op_rol:  c.lo = rol_r;
			srcpu_isa_pkg::op_neg:  c.lo = neg_r;
			srcpu_isa_pkg::op_not:  c.lo = not_r;
			srcpu_isa_pkg::op_mul:  c = mul_r;   // full 64 bits
			default:                c = '0;      // div result comes from the divider
		endcase
	end

endmodule

`default_nettype wire

// File: srcpu_booth_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "srcpu_defs.svh"

module srcpu_booth_mul (
	input  wire srcpu_dp_pkg::word_t  m,   // multiplicand
	input  wire srcpu_dp_pkg::word_t  q,   // multiplier
	output srcpu_dp_pkg::dword_t      product
);

	localparam int w = `SRC_WORD_W;

	logic [2*w-1:0] m_ext;
	logic [w:0]     q_ext;      // q with the implied zero below bit 0
	logic [2*w-1:0] pp [w];     // one partial product per multiplier bit
	logic [2*w-1:0] acc;

	assign m_ext = {{w{m[w-1]}}, m};
	assign q_ext = {q, 1'b0};

	// radix-2 recoding on each bit pair
	genvar i;
	generate
		for (i = 0; i < w; i++) begin : g_pp
			always_comb begin
				case (q_ext[i+1:i])
					2'b01:   pp[i] = m_ext << i;      // +m
					2'b10:   pp[i] = (-m_ext) << i;   // -m
					default: pp[i] = '0;
				endcase
			end
		end
	endgenerate

	always_comb begin
		acc = '0;
		for (int k = 0; k < w; k++)
			acc = acc + pp[k];
	end

	assign product = acc;

endmodule

`default_nettype wire

// File: srcpu_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "srcpu_defs.svh"

module srcpu_control (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          start,
	input  wire srcpu_isa_pkg::instr_t         instr,
	input  wire logic                          div_done,
	output srcpu_dp_pkg::dp_ctrl_t             ctrl,
	output srcpu_isa_pkg::op_t                 alu_op,
	output logic [$clog2(`SRC_NREG)-1:0]       rc_addr,
	output logic [$clog2(`SRC_NREG)-1:0]       ra_addr,
	output logic [$clog2(`SRC_NREG)-1:0]       rb_addr,
	output srcpu_dp_pkg::word_t                imm,
	output logic                               busy,
	output logic                               done
);

	typedef enum logic [2:0] {
		st_idle,
		st_exec,      // Z <= alu(Y, bus), or divider kick
		st_div_wait,
		st_wr_lo,     // rc or LO <= zlo
		st_wr_hi      // HI <= zhi
	} state_t;

	state_t state, state_nxt;
	srcpu_isa_pkg::instr_t instr_q;
	srcpu_isa_pkg::instr_t cur;   // live instruction, input while idle
	logic uses_imm;
	logic two_write;

	// the Y load happens on the same edge that samples start
	assign cur = (state == st_idle) ? instr : instr_q;

	assign uses_imm = cur.op inside {srcpu_isa_pkg::op_ldi, srcpu_isa_pkg::op_addi,
		srcpu_isa_pkg::op_andi, srcpu_isa_pkg::op_ori};
	assign two_write = cur.op inside {srcpu_isa_pkg::op_mul, srcpu_isa_pkg::op_div};

	assign alu_op  = cur.op;
	assign ra_addr = cur.ra;
	assign rb_addr = cur.rb;
	assign rc_addr = cur.rc;
	// zero while idle so ldi clears Y through the immediate path
	assign imm = (state == st_idle) ? '0 :
		{{(`SRC_WORD_W-16){instr_q.imm[15]}}, instr_q.imm};
	assign busy = (state != st_idle);

	always_comb begin
		ctrl = '0;
		ctrl.bus_sel = srcpu_dp_pkg::bus_rb;
		state_nxt = state;
		case (state)
			st_idle: begin
				if (start) begin
					ctrl.y_in = 1'b1;
					ctrl.bus_sel = (cur.op == srcpu_isa_pkg::op_ldi) ?
						srcpu_dp_pkg::bus_imm : srcpu_dp_pkg::bus_ra;
					state_nxt = st_exec;
				end
			end
			st_exec: begin
				ctrl.bus_sel = uses_imm ? srcpu_dp_pkg::bus_imm : srcpu_dp_pkg::bus_rb;
				if (cur.op == srcpu_isa_pkg::op_div) begin
					ctrl.div_start = 1'b1;
					state_nxt = st_div_wait;
				end else begin
					ctrl.z_in = 1'b1;
					state_nxt = st_wr_lo;
				end
			end
			st_div_wait: begin
				ctrl.z_in = div_done;   // top routes the divider result into Z
				if (div_done)
					state_nxt = st_wr_lo;
			end
			st_wr_lo: begin
				ctrl.bus_sel = srcpu_dp_pkg::bus_zlo;
				if (two_write) begin
					ctrl.lo_in = 1'b1;
					state_nxt = st_wr_hi;
				end else begin
					ctrl.rc_in = 1'b1;
					state_nxt = st_idle;
				end
			end
			st_wr_hi: begin
				ctrl.bus_sel = srcpu_dp_pkg::bus_zhi;
				ctrl.hi_in = 1'b1;
				state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			done  <= 1'b0;
		end else begin
			state <= state_nxt;
			// pulse once the last register write has landed
			done  <= (state != st_idle) && (state_nxt == st_idle);
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start)
			instr_q <= instr;
	end

endmodule

`default_nettype wire

// File: srcpu_defs.svh
`ifndef SRCPU_DEFS_SVH
`define SRCPU_DEFS_SVH

// data word width
`define SRC_WORD_W 32

// general purpose registers r0..r15
`define SRC_NREG 16

// host address map covers r0..r15, then HI at 16 and LO at 17
`define SRC_RADDR_W 5

// upper bound in cycles for any instruction to finish, divide included
`define SRC_DIV_TIMEOUT 64

`endif

// File: srcpu_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "srcpu_defs.svh"

module srcpu_divider (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  start,
	input  wire srcpu_dp_pkg::word_t   dividend,
	input  wire srcpu_dp_pkg::word_t   divisor,
	output srcpu_dp_pkg::dword_t       result,   // hi remainder, lo quotient
	output logic                       done
);

	localparam int w = `SRC_WORD_W;

	logic             running;
	logic             fixing;     // one cycle for remainder restore and signs
	logic [5:0]       cnt;
	logic signed [w:0] rem;       // partial remainder
	logic [w:0]       trial;
	srcpu_dp_pkg::word_t quo;
	srcpu_dp_pkg::word_t mag_d;
	srcpu_dp_pkg::word_t dvd;     // kept for the divide-by-zero case
	logic             neg_q, neg_r, div0;
	logic [w:0]       rem_fix;

	// add or subtract depending on the sign of the last remainder
	always_comb begin
		if (!rem[w])
			trial = {rem[w-1:0], quo[w-1]} - {1'b0, mag_d};
		else
			trial = {rem[w-1:0], quo[w-1]} + {1'b0, mag_d};
	end

	assign rem_fix = rem[w] ? rem + {1'b0, mag_d} : rem;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			fixing  <= 1'b0;
			cnt     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				fixing  <= 1'b0;
				cnt     <= 6'(w);
			end else if (running) begin
				cnt <= cnt - 6'd1;
				if (cnt == 6'd1) begin
					running <= 1'b0;
					fixing  <= 1'b1;
				end
			end else if (fixing) begin
				fixing <= 1'b0;
				done   <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem   <= '0;
			quo   <= dividend[w-1] ? -dividend : dividend;   // magnitudes
			mag_d <= divisor[w-1] ? -divisor : divisor;
			dvd   <= dividend;
			neg_q <= dividend[w-1] ^ divisor[w-1];
			neg_r <= dividend[w-1];
			div0  <= (divisor == '0);
		end else if (running) begin
			rem <= trial;
			quo <= {quo[w-2:0], ~trial[w]};
		end else if (fixing) begin
			if (div0) begin
				result.lo <= '1;
				result.hi <= dvd;
			end else begin
				result.lo <= neg_q ? -quo : quo;   // truncates toward zero
				result.hi <= neg_r ? -rem_fix[w-1:0] : rem_fix[w-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: srcpu_dp_pkg.sv
`default_nettype none

`include "srcpu_defs.svh"

package srcpu_dp_pkg;

	typedef logic [`SRC_WORD_W-1:0] word_t;

	// Z register layout, also used for mul and div results
	typedef struct packed {
		word_t hi;
		word_t lo;
	} dword_t;

	// who drives the internal bus
	typedef enum logic [2:0] {
		bus_rb,
		bus_ra,
		bus_imm,
		bus_zlo,
		bus_zhi
	} bus_sel_t;

	typedef struct packed {
		bus_sel_t bus_sel;
		logic     y_in;       // Y <= bus
		logic     z_in;       // Z <= alu or divider
		logic     rc_in;      // rc <= bus
		logic     hi_in;      // HI <= bus
		logic     lo_in;      // LO <= bus
		logic     div_start;  // kick the divider with Y and bus
	} dp_ctrl_t;

endpackage

`default_nettype wire

// File: srcpu_isa_pkg.sv
`default_nettype none

`include "srcpu_defs.svh"

package srcpu_isa_pkg;

	// opcode values follow the SRC encoding, ld (0) and st (2) are not implemented
	typedef enum logic [4:0] {
		op_ldi  = 5'd1,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_shr  = 5'd5,
		op_shra = 5'd6,
		op_shl  = 5'd7,
		op_ror  = 5'd8,
		op_rol  = 5'd9,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_mul  = 5'd15,
		op_div  = 5'd16,
		op_neg  = 5'd17,
		op_not  = 5'd18
	} op_t;

	typedef struct packed {
		op_t                           op;
		logic [$clog2(`SRC_NREG)-1:0] ra;   // source A, goes to Y
		logic [$clog2(`SRC_NREG)-1:0] rb;   // source B, goes on the bus
		logic [$clog2(`SRC_NREG)-1:0] rc;   // destination
		logic [15:0]                   imm;  // sign-extended when used
	} instr_t;

endpackage

`default_nettype wire

// File: srcpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "srcpu_defs.svh"

module srcpu_regfile (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          we,
	input  wire logic [$clog2(`SRC_NREG)-1:0]  waddr,
	input  wire srcpu_dp_pkg::word_t           wdata,
	input  wire logic                          hi_we,
	input  wire logic                          lo_we,
	input  wire logic [$clog2(`SRC_NREG)-1:0]  ra_addr,
	input  wire logic [$clog2(`SRC_NREG)-1:0]  rb_addr,
	output srcpu_dp_pkg::word_t                ra_data,
	output srcpu_dp_pkg::word_t                rb_data,
	input  wire logic                          host_we,
	input  wire logic [`SRC_RADDR_W-1:0]       host_waddr,
	input  wire srcpu_dp_pkg::word_t           host_wdata,
	input  wire logic [`SRC_RADDR_W-1:0]       host_raddr,
	output srcpu_dp_pkg::word_t                host_rdata
);

	localparam int idx_w   = $clog2(`SRC_NREG);
	localparam int addr_hi = `SRC_NREG;
	localparam int addr_lo = `SRC_NREG + 1;

	srcpu_dp_pkg::word_t gpr [`SRC_NREG];
	srcpu_dp_pkg::word_t hi, lo;
	logic host_gpr;   // host address hits r0..r15

	assign host_gpr = (host_waddr < `SRC_NREG);

	assign ra_data = gpr[ra_addr];
	assign rb_data = gpr[rb_addr];

	always_comb begin
		if (host_raddr < `SRC_NREG)
			host_rdata = gpr[host_raddr[idx_w-1:0]];
		else if (host_raddr == addr_hi)
			host_rdata = hi;
		else if (host_raddr == addr_lo)
			host_rdata = lo;
		else
			host_rdata = '0;   // unmapped
	end

	// internal writes win; the top only lets the host in while idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `SRC_NREG; i++)
				gpr[i] <= '0;
			hi <= '0;
			lo <= '0;
		end else begin
			if (we)
				gpr[waddr] <= wdata;
			else if (host_we && host_gpr)
				gpr[host_waddr[idx_w-1:0]] <= host_wdata;
			if (hi_we)
				hi <= wdata;
			else if (host_we && host_waddr == addr_hi)
				hi <= host_wdata;
			if (lo_we)
				lo <= wdata;
			else if (host_we && host_waddr == addr_lo)
				lo <= host_wdata;
		end
	end

endmodule

`default_nettype wire

// File: srcpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "srcpu_defs.svh"

module srcpu_top (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      start,
	input  wire srcpu_isa_pkg::instr_t     instr,
	output logic                           busy,
	output logic                           done,
	input  wire logic                      host_we,
	input  wire logic [`SRC_RADDR_W-1:0]   host_waddr,
	input  wire srcpu_dp_pkg::word_t       host_wdata,
	input  wire logic [`SRC_RADDR_W-1:0]   host_raddr,
	output srcpu_dp_pkg::word_t            host_rdata
);

	srcpu_dp_pkg::dp_ctrl_t ctrl;
	srcpu_isa_pkg::op_t     alu_op;
	logic [$clog2(`SRC_NREG)-1:0] ra_addr, rb_addr, rc_addr;
	srcpu_dp_pkg::word_t    imm, ra_data, rb_data, bus, y;
	srcpu_dp_pkg::dword_t   alu_c, div_c, z;
	logic                   div_done;

	srcpu_control u_ctrl (
		.clk (clk), .rst_n (rst_n), .start (start), .instr (instr),
		.div_done (div_done), .ctrl (ctrl), .alu_op (alu_op), .rc_addr (rc_addr),
		.ra_addr (ra_addr), .rb_addr (rb_addr), .imm (imm), .busy (busy), .done (done)
	);

	srcpu_regfile u_rf (
		.clk (clk), .rst_n (rst_n), .we (ctrl.rc_in), .waddr (rc_addr), .wdata (bus),
		.hi_we (ctrl.hi_in), .lo_we (ctrl.lo_in), .ra_addr (ra_addr), .rb_addr (rb_addr),
		.ra_data (ra_data), .rb_data (rb_data),
		.host_we (host_we & ~busy),   // host is locked out while an instruction runs
		.host_waddr (host_waddr), .host_wdata (host_wdata),
		.host_raddr (host_raddr), .host_rdata (host_rdata)
	);

	srcpu_alu u_alu (.a (y), .b (bus), .op (alu_op), .c (alu_c));

	srcpu_divider u_div (
		.clk (clk), .rst_n (rst_n), .start (ctrl.div_start), .dividend (y),
		.divisor (bus), .result (div_c), .done (div_done)
	);

	always_comb begin
		case (ctrl.bus_sel)
			srcpu_dp_pkg::bus_ra:  bus = ra_data;
			srcpu_dp_pkg::bus_imm: bus = imm;
			srcpu_dp_pkg::bus_zlo: bus = z.lo;
			srcpu_dp_pkg::bus_zhi: bus = z.hi;
			default:               bus = rb_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ctrl.y_in)
			y <= bus;
		if (ctrl.z_in)
			z <= (alu_op == srcpu_isa_pkg::op_div) ? div_c : alu_c;
	end

endmodule

`default_nettype wire

// File: tb_srcpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "srcpu_defs.svh"

module tb_srcpu;

	localparam logic [`SRC_RADDR_W-1:0] addr_hi = 5'd16;
	localparam logic [`SRC_RADDR_W-1:0] addr_lo = 5'd17;

	logic                      clk;
	logic                      rst_n;
	logic                      start;
	srcpu_isa_pkg::instr_t     instr;
	logic                      busy;
	logic                      done;
	logic                      host_we;
	logic [`SRC_RADDR_W-1:0]   host_waddr;
	srcpu_dp_pkg::word_t       host_wdata;
	logic [`SRC_RADDR_W-1:0]   host_raddr;
	srcpu_dp_pkg::word_t       host_rdata;
	integer                    seed;

	srcpu_top dut (
		.clk (clk), .rst_n (rst_n), .start (start), .instr (instr), .busy (busy),
		.done (done), .host_we (host_we), .host_waddr (host_waddr),
		.host_wdata (host_wdata), .host_raddr (host_raddr), .host_rdata (host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_word(input string name, input srcpu_dp_pkg::word_t exp,
		input srcpu_dp_pkg::word_t act);
		if (act !== exp)
			abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_dword(input string name, input srcpu_dp_pkg::dword_t exp,
		input srcpu_dp_pkg::dword_t act);
		if (act !== exp)
			abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("Mismatch %s latency: expected %0d, actual %0d", name, exp, act));
	endtask

	function automatic srcpu_isa_pkg::instr_t make_instr(input srcpu_isa_pkg::op_t op,
		input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc,
		input logic [15:0] imm);
		srcpu_isa_pkg::instr_t i;
		i.op = op;
		i.ra = ra;
		i.rb = rb;
		i.rc = rc;
		i.imm = imm;
		return i;
	endfunction

	// reference for every single-word operation, a from ra and b from rb
	function automatic srcpu_dp_pkg::word_t model_word(input srcpu_isa_pkg::op_t op,
		input srcpu_dp_pkg::word_t a, input srcpu_dp_pkg::word_t b, input logic [15:0] imm);
		srcpu_dp_pkg::word_t ix;
		int s;
		ix = {{16{imm[15]}}, imm};
		s = int'(b[4:0]);
		case (op)
			srcpu_isa_pkg::op_ldi:  return ix;
			srcpu_isa_pkg::op_add:  return a + b;
			srcpu_isa_pkg::op_sub:  return a - b;
			srcpu_isa_pkg::op_and:  return a & b;
			srcpu_isa_pkg::op_or:   return a | b;
			srcpu_isa_pkg::op_addi: return a + ix;
			srcpu_isa_pkg::op_andi: return a & ix;
			srcpu_isa_pkg::op_ori:  return a | ix;
			srcpu_isa_pkg::op_neg:  return 32'd0 - a;
			srcpu_isa_pkg::op_not:  return ~a;
			srcpu_isa_pkg::op_shr:  return a >> s;
			srcpu_isa_pkg::op_shra: return $signed(a) >>> s;
			srcpu_isa_pkg::op_shl:  return a << s;
			srcpu_isa_pkg::op_ror:  return (s == 0) ? a : ((a >> s) | (a << (32 - s)));
			srcpu_isa_pkg::op_rol:  return (s == 0) ? a : ((a << s) | (a >> (32 - s)));
			default:                return '0;
		endcase
	endfunction

	task automatic host_write(input logic [`SRC_RADDR_W-1:0] addr,
		input srcpu_dp_pkg::word_t data);
		@(posedge clk);
		host_we <= 1'b1;
		host_waddr <= addr;
		host_wdata <= data;
		@(posedge clk);   // write edge
		host_we <= 1'b0;
	endtask

	task automatic host_read(input logic [`SRC_RADDR_W-1:0] addr,
		output srcpu_dp_pkg::word_t data);
		@(posedge clk);
		host_raddr <= addr;
		@(negedge clk);
		data = host_rdata;
	endtask

	// returns on the edge that samples start
	task automatic pulse_start(input srcpu_isa_pkg::instr_t i);
		@(posedge clk);
		start <= 1'b1;
		instr <= i;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// counts clock cycles after the sampling edge until done is seen
	task automatic wait_done(input string name, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!done && cycles < `SRC_DIV_TIMEOUT);
		if (!done)
			abort_run($sformatf("timeout in %s, no done after %0d cycles", name, cycles));
	endtask

	task automatic exec_word(input srcpu_isa_pkg::op_t op, input srcpu_dp_pkg::word_t a,
		input srcpu_dp_pkg::word_t b, input logic [15:0] imm);
		srcpu_dp_pkg::word_t res;
		int cycles;
		host_write(5'd1, a);
		host_write(5'd2, b);
		host_write(5'd3, 32'hdead_beef);   // stale value, a missed write shows up
		pulse_start(make_instr(op, 4'd1, 4'd2, 4'd3, imm));
		wait_done(op.name(), cycles);
		check_cycles(op.name(), 3, cycles);
		host_read(5'd3, res);
		check_word(op.name(), model_word(op, a, b, imm), res);
	endtask

	task automatic exec_mul(input srcpu_dp_pkg::word_t a, input srcpu_dp_pkg::word_t b);
		longint pa;
		longint pb;
		logic [63:0] prod;
		srcpu_dp_pkg::dword_t exp;
		srcpu_dp_pkg::dword_t act;
		int cycles;
		pa = $signed(a);
		pb = $signed(b);
		prod = pa * pb;
		exp.hi = prod[63:32];
		exp.lo = prod[31:0];
		host_write(5'd1, a);
		host_write(5'd2, b);
		pulse_start(make_instr(srcpu_isa_pkg::op_mul, 4'd1, 4'd2, 4'd0, 16'h0));
		wait_done("mul", cycles);
		check_cycles("mul", 4, cycles);
		host_read(addr_hi, act.hi);
		host_read(addr_lo, act.lo);
		check_dword("mul", exp, act);
	endtask

	task automatic exec_div(input srcpu_dp_pkg::word_t a, input srcpu_dp_pkg::word_t b);
		longint pa;
		longint pb;
		longint q;
		longint r;
		srcpu_dp_pkg::dword_t exp;
		srcpu_dp_pkg::dword_t act;
		int cycles;
		pa = $signed(a);
		pb = $signed(b);
		if (b == '0) begin
			exp.lo = '1;
			exp.hi = a;
		end else begin
			q = pa / pb;   // truncates toward zero, remainder keeps the dividend sign
			r = pa % pb;
			exp.lo = q[31:0];
			exp.hi = r[31:0];
		end
		host_write(5'd1, a);
		host_write(5'd2, b);
		pulse_start(make_instr(srcpu_isa_pkg::op_div, 4'd1, 4'd2, 4'd0, 16'h0));
		wait_done("div", cycles);
		host_read(addr_hi, act.hi);
		host_read(addr_lo, act.lo);
		check_dword("div", exp, act);
	endtask

	task automatic test_protocol();
		srcpu_dp_pkg::word_t res;
		int cycles;
		host_write(5'd1, 32'h0000_0100);
		host_write(5'd2, 32'h0000_0023);
		host_write(5'd9, 32'h5555_aaaa);
		host_write(5'd10, 32'h0f0f_0f0f);
		@(posedge clk);
		start <= 1'b1;
		instr <= make_instr(srcpu_isa_pkg::op_add, 4'd1, 4'd2, 4'd3, 16'h0);
		@(posedge clk);
		// start stays high and a host write arrives while the DUT sits in exec
		instr <= make_instr(srcpu_isa_pkg::op_ldi, 4'd0, 4'd0, 4'd9, 16'h1234);
		host_we <= 1'b1;
		host_waddr <= 5'd10;
		host_wdata <= 32'hffff_0000;
		@(posedge clk);
		start <= 1'b0;
		host_we <= 1'b0;
		wait_done("protocol", cycles);
		if (busy)
			abort_run("a start while busy launched a second instruction");
		host_read(5'd3, res);
		check_word("protocol add", 32'h0000_0123, res);
		host_read(5'd9, res);
		check_word("protocol late start", 32'h5555_aaaa, res);
		host_read(5'd10, res);
		check_word("protocol host write", 32'h0f0f_0f0f, res);
	endtask

	initial begin
		srcpu_dp_pkg::word_t a;
		srcpu_dp_pkg::word_t b;
		logic [15:0] imm;
		seed = 32'h9f55;
		rst_n = 1'b0;
		start = 1'b0;
		instr = '0;
		host_we = 1'b0;
		host_waddr = '0;
		host_wdata = '0;
		host_raddr = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		for (int n = 0; n < 8; n++) begin
			a = $random(seed);
			b = $random(seed);
			exec_word(srcpu_isa_pkg::op_and, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_or, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_add, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_sub, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_neg, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_not, a, b, 16'h0);
		end

		// upper bits of b set so only the low five bits may count
		for (int n = 0; n < 8; n++) begin
			a = $random(seed);
			case (n)
				0:       b = 32'hffff_ffe0;
				1:       b = 32'h0000_005f;
				default: b = $random(seed);
			endcase
			exec_word(srcpu_isa_pkg::op_shr, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_shra, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_shl, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_ror, a, b, 16'h0);
			exec_word(srcpu_isa_pkg::op_rol, a, b, 16'h0);
		end

		for (int n = 0; n < 8; n++) begin
			a = $random(seed);
			imm = (n == 0) ? 16'h8000 : (n == 1) ? 16'h7fff : 16'($random(seed));
			exec_word(srcpu_isa_pkg::op_ldi, a, 32'h0, imm);
			exec_word(srcpu_isa_pkg::op_addi, a, 32'h0, imm);
			exec_word(srcpu_isa_pkg::op_andi, a, 32'h0, imm);
			exec_word(srcpu_isa_pkg::op_ori, a, 32'h0, imm);
		end

		exec_mul(32'h8000_0000, 32'hffff_ffff);
		exec_mul(32'h8000_0000, 32'h8000_0000);
		exec_mul(32'h7fff_ffff, 32'h7fff_ffff);
		exec_mul(32'hffff_ffff, 32'hffff_ffff);
		exec_mul(32'h0, 32'h1234_5678);
		for (int n = 0; n < 8; n++)
			exec_mul($random(seed), $random(seed));

		exec_div(32'd100, 32'd7);
		exec_div(-32'sd100, 32'd7);
		exec_div(32'd100, -32'sd7);
		exec_div(-32'sd100, -32'sd7);
		exec_div(32'h8000_0000, 32'hffff_ffff);
		exec_div(32'h1234_5678, 32'h0);
		exec_div(32'h8765_4321, 32'h0);
		for (int n = 0; n < 8; n++)
			exec_div($random(seed), $random(seed) >>> (n * 3));

		test_protocol();

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
